/* cu_vertex_pipeline.f */
logic/graph_types_pkg.sv
logic/cu_buffer_pkg.sv
logic/vertex_job_fifo.sv
logic/vertex_job_filter.sv
logic/vertex_edge_expander.sv
logic/cu_vertex_pipeline.sv
verification/cu_vertex_pipeline_assert.sv
verification/cu_vertex_pipeline_tb.sv

/* logic/cu_buffer_pkg.sv */
// Job buffer status flags and sizing constants; referenced by package scope from FIFO and stages
package cu_buffer_pkg;

	////////////////////
	// Sizing
	////////////////////

	// Default job buffer depth, entries
	localparam int JOB_BUFFER_DEPTH_DEFAULT = 16;

	// Free entries left when almost full rises
	// Covers requests still in flight through the registered stages
	localparam int ALFULL_SLACK = 4;

	////////////////////
	// Status
	////////////////////

	// Flags of one job FIFO, gathered in one place per stage
	typedef struct packed {
		logic full;
		logic alfull;
		logic valid;
		logic empty;
	} buffer_status_t;

endpackage

/* logic/cu_vertex_pipeline.sv */
// Top of the vertex job front end; chains filter and expander and sets the buffer depth
`timescale 1ns/100ps

module cu_vertex_pipeline #(
	parameter int DEPTH = cu_buffer_pkg::JOB_BUFFER_DEPTH_DEFAULT
) (
	input  logic                           clock,
	input  logic                           rstn,
	input  logic                           enabled_in,
	input  graph_types_pkg::vertex_job_t   vertex_in,
	output logic                           vertex_request_unfiltered,
	input  logic                           edge_request,
	output graph_types_pkg::edge_job_t     edge_out,
	output graph_types_pkg::vertex_count_t vertex_job_counter_filtered,
	output graph_types_pkg::vertex_count_t edge_counter_emitted
);

	// Surviving vertices, one cycle strobes
	graph_types_pkg::vertex_job_t filtered_vertex;
	// Expander asks for more vertices
	logic                         vertex_request_filtered;

	////////////////////
	// Filter stage
	////////////////////

	// Source side paced by vertex_request_unfiltered
	vertex_job_filter #(
		.DEPTH(DEPTH)
	) u_vertex_job_filter (
		.clock                      (clock),
		.rstn                       (rstn),
		.enabled_in                 (enabled_in),
		.vertex_in                  (vertex_in),
		.vertex_request_filtered    (vertex_request_filtered),
		.vertex_request_unfiltered  (vertex_request_unfiltered),
		.vertex_out                 (filtered_vertex),
		.vertex_job_counter_filtered(vertex_job_counter_filtered)
	);

	////////////////////
	// Expander stage
	////////////////////

	// Sink side paced by edge_request
	vertex_edge_expander #(
		.DEPTH(DEPTH)
	) u_vertex_edge_expander (
		.clock               (clock),
		.rstn                (rstn),
		.vertex_in           (filtered_vertex),
		.vertex_request      (vertex_request_filtered),
		.edge_request        (edge_request),
		.edge_out            (edge_out),
		.edge_counter_emitted(edge_counter_emitted)
	);

endmodule

/* logic/graph_types_pkg.sv */
// Vertex and edge job types shared by the compute unit front end; referenced by package scope
package graph_types_pkg;

	////////////////////
	// Field widths
	////////////////////

	localparam int VERTEX_ID_BITS      = 16;
	localparam int DEGREE_BITS         = 8;
	localparam int EDGE_INDEX_BITS     = 20;
	localparam int INVERSE_DEGREE_BITS = 16;
	localparam int VERTEX_COUNT_BITS   = 16;

	// Vertex identifier
	typedef logic [VERTEX_ID_BITS-1:0] vertex_id_t;
	// Number of outgoing edges
	typedef logic [DEGREE_BITS-1:0] degree_t;
	// Position in the edge array
	typedef logic [EDGE_INDEX_BITS-1:0] edge_index_t;
	// Fixed point 1/out_degree, zero means no contribution
	typedef logic [INVERSE_DEGREE_BITS-1:0] inverse_degree_t;
	// Filtered vertex and emitted edge counters
	typedef logic [VERTEX_COUNT_BITS-1:0] vertex_count_t;

	////////////////////
	// Job structs
	////////////////////

	// Vertex description as it travels through the stages
	typedef struct packed {
		vertex_id_t      id;
		degree_t         out_degree;
		edge_index_t     edges_idx;
		inverse_degree_t inverse_out_degree;
	} vertex_payload_t;

	// Vertex job, valid qualifies the payload for one cycle
	typedef struct packed {
		logic            valid;
		vertex_payload_t payload;
	} vertex_job_t;

	// One edge of a vertex, weight is the source inverse degree
	typedef struct packed {
		logic            valid;
		vertex_id_t      src_id;
		edge_index_t     edge_index;
		inverse_degree_t weight;
	} edge_job_t;

endpackage

/* logic/vertex_edge_expander.sv */
// Expander stage that queues vertex jobs and emits one edge job per outgoing edge on sink request
`timescale 1ns/100ps

module vertex_edge_expander #(
	parameter int DEPTH = cu_buffer_pkg::JOB_BUFFER_DEPTH_DEFAULT
) (
	input  logic                           clock,
	input  logic                           rstn,
	input  graph_types_pkg::vertex_job_t   vertex_in,
	output logic                           vertex_request,
	input  logic                           edge_request,
	output graph_types_pkg::edge_job_t     edge_out,
	output graph_types_pkg::vertex_count_t edge_counter_emitted
);

	typedef enum logic [1:0] {
		EXP_IDLE,
		EXP_FETCH,
		EXP_EXPAND
	} expander_state_t;

	expander_state_t state;

	cu_buffer_pkg::buffer_status_t   queue_status;
	graph_types_pkg::vertex_job_t    queue_data_out;
	logic                            queue_pop;
	logic                            request_ready;
	logic                            emit_edge;

	// Current vertex being expanded
	graph_types_pkg::vertex_id_t      cur_src_id;
	graph_types_pkg::inverse_degree_t cur_weight;
	graph_types_pkg::edge_index_t     cur_edge_index;
	graph_types_pkg::degree_t         edges_left;

	////////////////////
	// Vertex queue
	////////////////////

	// Set once after reset, request rises one clock later
	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			request_ready <= 1'b0;
		end else begin
			request_ready <= 1'b1;
		end
	end

	// Straight from the flags, the filter adds its own latch
	assign vertex_request = request_ready & ~(queue_status.alfull | queue_status.full);

	// Only pop from idle
	assign queue_pop = (state == EXP_IDLE) & ~queue_status.empty;

	vertex_job_fifo #(
		.DEPTH(DEPTH)
	) u_vertex_job_fifo (
		.clock   (clock),
		.rstn    (rstn),
		.push    (vertex_in.valid),
		.data_in (vertex_in),
		.full    (queue_status.full),
		.alfull  (queue_status.alfull),
		.pop     (queue_pop),
		.valid   (queue_status.valid),
		.data_out(queue_data_out),
		.empty   (queue_status.empty)
	);

	////////////////////
	// Expansion FSM
	////////////////////

	assign emit_edge = (state == EXP_EXPAND) & edge_request;

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			state                <= EXP_IDLE;
			edges_left           <= '0;
			edge_out             <= '0;
			edge_counter_emitted <= '0;
		end else begin
			edge_out.valid <= emit_edge;
			case (state)
				EXP_IDLE: begin
					if (queue_pop) begin
						state <= EXP_FETCH;
					end
				end
				EXP_FETCH: begin
					// Popped job lands here one clock after the pop
					if (queue_status.valid) begin
						edges_left <= queue_data_out.payload.out_degree;
						// Zero degree, nothing to emit
						state <= (queue_data_out.payload.out_degree == '0) ? EXP_IDLE : EXP_EXPAND;
					end
				end
				EXP_EXPAND: begin
					if (emit_edge) begin
						edge_out.src_id      <= cur_src_id;
						edge_out.edge_index  <= cur_edge_index;
						edge_out.weight      <= cur_weight;
						edge_counter_emitted <= edge_counter_emitted + 1'b1;
						edges_left           <= edges_left - 1'b1;
						// Last edge of this vertex
						if (edges_left == 8'd1) begin
							state <= EXP_IDLE;
						end
					end
				end
				default: state <= EXP_IDLE;
			endcase
		end
	end

	// Vertex fields, loaded on fetch and stepped per edge
	always_ff @(posedge clock) begin
		if ((state == EXP_FETCH) && queue_status.valid) begin
			cur_src_id     <= queue_data_out.payload.id;
			cur_weight     <= queue_data_out.payload.inverse_out_degree;
			cur_edge_index <= queue_data_out.payload.edges_idx;
		end else if (emit_edge) begin
			// Increasing edge index order
			cur_edge_index <= cur_edge_index + 1'b1;
		end
	end

endmodule

/* logic/vertex_job_fifo.sv */
// Synchronous job FIFO with almost full and a registered pop result; instantiated by both stages
`timescale 1ns/100ps

module vertex_job_fifo #(
	parameter int DEPTH = cu_buffer_pkg::JOB_BUFFER_DEPTH_DEFAULT
) (
	input  logic                         clock,
	input  logic                         rstn,
	input  logic                         push,
	input  graph_types_pkg::vertex_job_t data_in,
	output logic                         full,
	output logic                         alfull,
	input  logic                         pop,
	output logic                         valid,
	output graph_types_pkg::vertex_job_t data_out,
	output logic                         empty
);

	localparam int ADDR_W       = $clog2(DEPTH);
	localparam int CNT_W        = $clog2(DEPTH + 1);
	localparam int ALFULL_LEVEL = DEPTH - cu_buffer_pkg::ALFULL_SLACK;

	graph_types_pkg::vertex_job_t mem [DEPTH];

	logic [ADDR_W-1:0] wr_ptr;
	logic [ADDR_W-1:0] rd_ptr;
	logic [CNT_W-1:0]  count;
	logic              do_push;
	logic              do_pop;

	// Overflow and underflow requests are dropped
	assign do_push = push & ~full;
	assign do_pop  = pop & ~empty;

	////////////////////
	// Flags
	////////////////////

	assign full   = (count == CNT_W'(DEPTH));
	assign empty  = (count == '0);
	// Fewer than ALFULL_SLACK entries free
	assign alfull = (count > CNT_W'(ALFULL_LEVEL));

	////////////////////
	// Pointers and count
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			valid  <= 1'b0;
		end else begin
			if (do_push) begin
				// Wrap explicitly, depth need not be a power of two
				wr_ptr <= (wr_ptr == ADDR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == ADDR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			// Net occupancy change
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			// One clock pulse per pop
			valid <= do_pop;
		end
	end

	////////////////////
	// Storage and read register
	////////////////////

	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= data_in;
		end
		// Read data lines up with valid
		if (do_pop) begin
			data_out <= mem[rd_ptr];
		end
	end

endmodule

/* logic/vertex_job_filter.sv */
// Filter stage that drops zero weight vertices, counts them and buffers the rest for the expander
`timescale 1ns/100ps

module vertex_job_filter #(
	parameter int DEPTH = cu_buffer_pkg::JOB_BUFFER_DEPTH_DEFAULT
) (
	input  logic                           clock,
	input  logic                           rstn,
	input  logic                           enabled_in,
	input  graph_types_pkg::vertex_job_t   vertex_in,
	input  logic                           vertex_request_filtered,
	output logic                           vertex_request_unfiltered,
	output graph_types_pkg::vertex_job_t   vertex_out,
	output graph_types_pkg::vertex_count_t vertex_job_counter_filtered
);

	logic enabled;

	graph_types_pkg::vertex_job_t   vertex_in_latched;
	logic                           vertex_request_filtered_latched;
	graph_types_pkg::vertex_job_t   buffer_data_out;
	graph_types_pkg::vertex_job_t   vertex_out_next;
	graph_types_pkg::vertex_count_t filtered_count;
	cu_buffer_pkg::buffer_status_t  buffer_status;

	logic drop_vertex;
	logic push_vertex;
	logic pop_vertex;

	////////////////////
	// Enable register
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			enabled <= 1'b0;
		end else begin
			enabled <= enabled_in;
		end
	end

	////////////////////
	// Input latch
	////////////////////

	// Frozen while disabled, job and request held
	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			vertex_in_latched               <= '0;
			vertex_request_filtered_latched <= 1'b0;
		end else if (enabled) begin
			vertex_in_latched               <= vertex_in;
			vertex_request_filtered_latched <= vertex_request_filtered;
		end
	end

	////////////////////
	// Drop or keep
	////////////////////

	// Gated by enable so a held job is seen once
	assign drop_vertex = enabled & vertex_in_latched.valid &
		~(|vertex_in_latched.payload.inverse_out_degree);
	assign push_vertex = enabled & vertex_in_latched.valid &
		(|vertex_in_latched.payload.inverse_out_degree);

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			filtered_count <= '0;
		end else if (drop_vertex) begin
			filtered_count <= filtered_count + 1'b1;
		end
	end

	////////////////////
	// Job buffer
	////////////////////

	// Pop only if the output register still updates next clock
	assign pop_vertex = enabled & enabled_in & vertex_request_filtered_latched &
		~buffer_status.empty;

	vertex_job_fifo #(
		.DEPTH(DEPTH)
	) u_vertex_job_fifo (
		.clock   (clock),
		.rstn    (rstn),
		.push    (push_vertex),
		.data_in (vertex_in_latched),
		.full    (buffer_status.full),
		.alfull  (buffer_status.alfull),
		.pop     (pop_vertex),
		.valid   (buffer_status.valid),
		.data_out(buffer_data_out),
		.empty   (buffer_status.empty)
	);

	// Stored valid bit is stale after the pop, use the pulse
	always_comb begin
		vertex_out_next         = buffer_data_out;
		vertex_out_next.valid   = buffer_status.valid;
	end

	////////////////////
	// Output registers
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			vertex_out                  <= '0;
			vertex_request_unfiltered   <= 1'b0;
			vertex_job_counter_filtered <= '0;
		end else if (enabled) begin
			vertex_out                  <= vertex_out_next;
			vertex_request_unfiltered   <= ~(buffer_status.alfull | buffer_status.full);
			vertex_job_counter_filtered <= filtered_count;
		end else begin
			// Single cycle strobe, no repeat while frozen
			vertex_out.valid <= 1'b0;
		end
	end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build the vertex job front end testbench with Verilator, run it and check the log.
set -u
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -j 0 \
	--top-module cu_vertex_pipeline_tb \
	-f cu_vertex_pipeline.f \
	-o cu_vertex_pipeline_sim > build.log 2>&1 \
	&& ./obj_dir/cu_vertex_pipeline_sim > sim.log 2>&1 \
	|| { echo "build or simulation run failed, see build.log and sim.log"; exit 1; }

grep -qx "RESULT: PASS" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }

/* verification/cu_vertex_pipeline_assert.sv */
// Concurrent push, pop and reset checks for the job FIFO; bound to every vertex_job_fifo instance
`timescale 1ns/100ps

module cu_vertex_pipeline_assert (
	input logic clock,
	input logic rstn,
	input logic push,
	input logic pop,
	input logic full,
	input logic alfull,
	input logic empty,
	input logic valid
);

	////////////////////
	// Buffer rules
	////////////////////

	// Almost full slack must keep writers off a full buffer
	property push_not_full;
		@(posedge clock) disable iff (!rstn)
		push |-> !full;
	endproperty

	// Readers only pop what is there
	property pop_not_empty;
		@(posedge clock) disable iff (!rstn)
		pop |-> !empty;
	endproperty

	// First clock out of reset, no push, no pop, nothing valid, buffer empty
	property clear_after_reset;
		@(posedge clock)
		$rose(rstn) |-> (!push && !pop && !valid && !full && !alfull && empty);
	endproperty

	push_not_full_check: assert property (push_not_full)
		else $error("job buffer pushed while full");
	pop_not_empty_check: assert property (pop_not_empty)
		else $error("job buffer popped while empty");
	clear_after_reset_check: assert property (clear_after_reset)
		else $error("job buffer requests or flags not cleared right after reset");

endmodule

/* verification/cu_vertex_pipeline_tb.sv */
// Testbench for the vertex job front end; LFSR driven jobs checked against an edge job model
`timescale 1ns/100ps

module cu_vertex_pipeline_tb;

	localparam int DEPTH         = 16;
	localparam int STIM_CYCLES   = 3000;
	localparam int SETTLE_CYCLES = 4;

	logic                           clock;
	logic                           rstn;
	logic                           enabled_in;
	graph_types_pkg::vertex_job_t   vertex_in;
	logic                           vertex_request_unfiltered;
	logic                           edge_request;
	graph_types_pkg::edge_job_t     edge_out;
	graph_types_pkg::vertex_count_t vertex_job_counter_filtered;
	graph_types_pkg::vertex_count_t edge_counter_emitted;

	// Reference model
	graph_types_pkg::edge_job_t     expected_edges [$];
	int unsigned                    filtered_total = 0;
	int unsigned                    edge_total = 0;
	// Run bookkeeping
	int unsigned                    error_count = 0;
	int unsigned                    check_count = 0;
	int unsigned                    cycle_count = 0;
	logic [31:0]                    lfsr_state;
	int                             stretch_left;
	int                             pause_left;
	// Copy of the DUT enable register
	logic                           enable_q;
	logic                           enable_q_prev;
	logic                           request_prev;
	logic                           saw_request_drop;
	graph_types_pkg::vertex_count_t counter_prev;

	cu_vertex_pipeline #(
		.DEPTH(DEPTH)
	) u_cu_vertex_pipeline (
		.clock                      (clock),
		.rstn                       (rstn),
		.enabled_in                 (enabled_in),
		.vertex_in                  (vertex_in),
		.vertex_request_unfiltered  (vertex_request_unfiltered),
		.edge_request               (edge_request),
		.edge_out                   (edge_out),
		.vertex_job_counter_filtered(vertex_job_counter_filtered),
		.edge_counter_emitted       (edge_counter_emitted)
	);

	bind vertex_job_fifo cu_vertex_pipeline_assert u_fifo_assert (
		.clock (clock),
		.rstn  (rstn),
		.push  (push),
		.pop   (pop),
		.full  (full),
		.alfull(alfull),
		.empty (empty),
		.valid (valid)
	);

	////////////////////
	// Clock and watchdog
	////////////////////

	always #5 clock = ~clock;

	always @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enable_q <= 1'b0;
		end else begin
			enable_q <= enabled_in;
		end
	end

	// Limit grows with the edges the model expects
	always @(posedge clock) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > 10 * (STIM_CYCLES + edge_total)) begin
			$display("timeout, run still busy after %0d cycles", cycle_count);
			$display("checks %0d, errors %0d", check_count, error_count);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	////////////////////
	// Random source
	////////////////////

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		logic feedback;
		feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
		return {state[30:0], feedback};
	endfunction

	// One step per bit taken
	task automatic take_bits(input int count, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < count; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			value      = {value[30:0], lfsr_state[0]};
		end
	endtask

	////////////////////
	// Model and checks
	////////////////////

	// Zero inverse degree counts as filtered, else one edge per out edge
	task automatic add_to_model(input graph_types_pkg::vertex_job_t job);
		graph_types_pkg::edge_job_t edge_job;
		if (job.payload.inverse_out_degree == '0) begin
			filtered_total++;
		end else begin
			for (int k = 0; k < int'(job.payload.out_degree); k++) begin
				edge_job.valid      = 1'b1;
				edge_job.src_id     = job.payload.id;
				edge_job.edge_index = job.payload.edges_idx + graph_types_pkg::edge_index_t'(k);
				edge_job.weight     = job.payload.inverse_out_degree;
				expected_edges.push_back(edge_job);
				edge_total++;
			end
		end
	endtask

	task automatic check_outputs();
		graph_types_pkg::edge_job_t head;
		if (edge_out.valid) begin
			check_count++;
			assert (expected_edges.size() > 0) else begin
				error_count++;
				$display("edge job 0x%h came out while no edge was expected", edge_out);
			end
			if (expected_edges.size() > 0) begin
				head = expected_edges.pop_front();
				assert (edge_out.src_id == head.src_id) else begin
					error_count++;
					$display("error edge_out.src_id 0x%h expected 0x%h, edge 0x%h expected 0x%h",
						edge_out.src_id, head.src_id, edge_out, head);
				end
				assert (edge_out.edge_index == head.edge_index) else begin
					error_count++;
					$display("error edge_out.edge_index 0x%h expected 0x%h, edge 0x%h expected 0x%h",
						edge_out.edge_index, head.edge_index, edge_out, head);
				end
				assert (edge_out.weight == head.weight) else begin
					error_count++;
					$display("error edge_out.weight 0x%h expected 0x%h, edge 0x%h expected 0x%h",
						edge_out.weight, head.weight, edge_out, head);
				end
			end
		end
		// Enable register low over the last clock, counter must hold
		if (!enable_q_prev) begin
			check_count++;
			assert (vertex_job_counter_filtered == counter_prev) else begin
				error_count++;
				$display("error vertex_job_counter_filtered 0x%h expected 0x%h while disabled",
					vertex_job_counter_filtered, counter_prev);
			end
		end
		// A fall here only comes from the almost full flag
		if (request_prev && !vertex_request_unfiltered) begin
			saw_request_drop = 1'b1;
		end
		request_prev  = vertex_request_unfiltered;
		enable_q_prev = enable_q;
		counter_prev  = vertex_job_counter_filtered;
	endtask

	////////////////////
	// Stimulus
	////////////////////

	task automatic drive_inputs();
		logic [31:0]                  r;
		graph_types_pkg::vertex_job_t job;
		// Sink level in stretches, low ones long enough to fill both buffers
		if (stretch_left == 0) begin
			take_bits(1, r);
			edge_request = r[0];
			if (r[0]) begin
				take_bits(6, r);
				stretch_left = 1 + int'(r[5:0]);
			end else begin
				take_bits(7, r);
				stretch_left = 8 + int'(r[6:0]);
			end
		end else begin
			stretch_left--;
		end
		// Short enable pauses, about one start in 32 cycles
		if (pause_left == 0) begin
			take_bits(5, r);
			if (r[4:0] == 5'd0) begin
				take_bits(3, r);
				pause_left = 2 + int'(r[2:0]);
			end
		end
		if (pause_left > 0) begin
			pause_left--;
		end
		enabled_in = (pause_left == 0);
		// Jobs only when the next clock will latch them
		vertex_in = '0;
		if (vertex_request_unfiltered && enable_q) begin
			take_bits(2, r);
			if (r[1:0] != 2'd0) begin
				job.valid = 1'b1;
				take_bits(16, r);
				job.payload.id = r[15:0];
				take_bits(3, r);
				job.payload.out_degree = graph_types_pkg::degree_t'(r[2:0]);
				take_bits(20, r);
				job.payload.edges_idx = r[19:0];
				take_bits(2, r);
				// Zero inverse for one job in four
				job.payload.inverse_out_degree = '0;
				if (r[1:0] != 2'd0) begin
					take_bits(16, r);
					job.payload.inverse_out_degree = r[15:0];
				end
				vertex_in = job;
				add_to_model(job);
			end
		end
	endtask

	initial begin
		clock            = 1'b0;
		rstn             = 1'b0;
		enabled_in       = 1'b0;
		vertex_in        = '0;
		edge_request     = 1'b0;
		lfsr_state       = 32'hdf3e_17c1;
		stretch_left     = 0;
		pause_left       = 0;
		enable_q_prev    = 1'b0;
		request_prev     = 1'b0;
		saw_request_drop = 1'b0;
		counter_prev     = '0;
		repeat (5) @(negedge clock);
		rstn = 1'b1;
		for (int n = 0; n < STIM_CYCLES; n++) begin
			@(negedge clock);
			check_outputs();
			drive_inputs();
		end
		// Drain with the sink always ready
		do begin
			@(negedge clock);
			check_outputs();
			vertex_in    = '0;
			enabled_in   = 1'b1;
			edge_request = 1'b1;
		end while (expected_edges.size() != 0 ||
			vertex_job_counter_filtered != graph_types_pkg::vertex_count_t'(filtered_total));
		// Catch stray edges after the last expected one
		repeat (SETTLE_CYCLES) begin
			@(negedge clock);
			check_outputs();
		end
		check_count++;
		assert (edge_counter_emitted == graph_types_pkg::vertex_count_t'(edge_total)) else begin
			error_count++;
			$display("error edge_counter_emitted 0x%h expected 0x%h",
				edge_counter_emitted, graph_types_pkg::vertex_count_t'(edge_total));
		end
		check_count++;
		assert (saw_request_drop) else begin
			error_count++;
			$display("vertex_request_unfiltered never fell while the sink held back");
		end
		$display("checks %0d, errors %0d, edges %0d, filtered %0d",
			check_count, error_count, edge_total, filtered_total);
		if (error_count == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule
